/* sim.f */
+incdir+rtl
rtl/drawPkg.sv
rtl/ctrlPkg.sv
rtl/pixelBus.sv
rtl/tileCmdBus.sv
rtl/keyDecode.sv
rtl/tileAnimator.sv
rtl/drawArbiter.sv
rtl/tileDisplay.sv
verif/pixelChecker.sv
verif/tbTop.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tbTop -f sim.f -o simTile
./obj_dir/simTile | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "TESTS PASSED" sim.log

/* verif/tbTop.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tile_settings.svh"

module tbTop;
    import drawPkg::*;

    typedef enum logic [1:0] {actNone, actSetColor, actFaster, actSlower} keyAct;

    typedef struct packed {
        keyAct   act;
        tileIdx  sel;
        pixColor col;
        int      hold;       // cycles the key stays down
        int      waitLen;    // cycles before the results are checked
        pixColor exp0;       // expected draw colour per tile
        pixColor exp1;
        logic    chkSpeed;
        logic    chkWrap;
    } testEntry;

    localparam int white = (1 << `COLOR_BITS) - 1;

    logic    Clock, arstN;
    logic    keySetColor, keyFaster, keySlower;
    tileIdx  selTile;
    pixColor newColor;
    xCoord   outX;
    yCoord   outY;
    pixColor outColor;
    logic    outWrite;

    testEntry tbl [$];
    string    names [$];
    int       waitSum = 0;

    tileDisplay i_dut (
        .Clock       (Clock),
        .arstN       (arstN),
        .keySetColor (keySetColor),
        .keyFaster   (keyFaster),
        .keySlower   (keySlower),
        .selTile     (selTile),
        .newColor    (newColor),
        .pixX        (outX),
        .pixY        (outY),
        .pixColor    (outColor),
        .pixWrite    (outWrite)
    );

    pixelChecker pixChk (
        .Clock (Clock),
        .arstN (arstN),
        .x     (outX),
        .y     (outY),
        .color (outColor),
        .write (outWrite)
    );

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;                     // 4 ns period
    end

    task automatic addTest(input string name, input keyAct act, input int sel, input int col,
                           input int hold, input int waitLen, input int exp0, input int exp1,
                           input bit spd, input bit wrp);
        testEntry ent;
        ent.act      = act;
        ent.sel      = tileIdx'(sel);
        ent.col      = pixColor'(col);
        ent.hold     = hold;
        ent.waitLen  = waitLen;
        ent.exp0     = pixColor'(exp0);
        ent.exp1     = pixColor'(exp1);
        ent.chkSpeed = spd;
        ent.chkWrap  = wrp;
        tbl.push_back(ent);
        names.push_back(name);
        waitSum += waitLen;
    endtask

    task automatic runTest(input int e);
        testEntry ent;
        ent = tbl[e];
        @(negedge Clock);
        pixChk.startTest(names[e]);
        @(posedge Clock);
        selTile     <= ent.sel;
        newColor    <= ent.col;
        keySetColor <= (ent.act == actSetColor);
        keyFaster   <= (ent.act == actFaster);
        keySlower   <= (ent.act == actSlower);
        repeat (ent.hold) @(posedge Clock);
        keySetColor <= 1'b0;                           // release before the next press
        keyFaster   <= 1'b0;
        keySlower   <= 1'b0;
        repeat (ent.waitLen) @(posedge Clock);
        @(negedge Clock);
        pixChk.endTest(int'(ent.exp0), int'(ent.exp1), ent.chkSpeed, ent.chkWrap);
    endtask

    initial begin
        arstN       = 1'b0;
        keySetColor = 1'b0;
        keyFaster   = 1'b0;
        keySlower   = 1'b0;
        selTile     = '0;
        newColor    = '0;
        // name, key, sel, colour, hold, wait, colour 0, colour 1, speed, wrap
        addTest("initDraw",   actNone,     0, 0, 1,  450,  white, white, 0, 0);
        addTest("redraw",     actNone,     0, 0, 1,  600,  white, white, 0, 0);
        addTest("colorTile1", actSetColor, 1, 5, 6,  600,  white, 5,     0, 0);
        addTest("colorZero",  actSetColor, 1, 0, 6,  600,  white, white, 0, 0);
        addTest("faster1",    actFaster,   0, 0, 20, 40,   white, white, 0, 0);
        addTest("faster2",    actFaster,   0, 0, 20, 40,   white, white, 0, 0);
        addTest("faster3",    actFaster,   0, 0, 20, 40,   white, white, 0, 0);
        addTest("speed",      actNone,     0, 0, 1,  2048, white, white, 1, 0);
        addTest("wrap",       actNone,     0, 0, 1,  3000, white, white, 0, 1);
        repeat (10) @(posedge Clock);
        arstN <= 1'b1;
        for (int e = 0; e < tbl.size(); e++) runTest(e);
        @(negedge Clock);
        pixChk.reportCounts();
        if (pixChk.failCount == 0 && pixChk.testErrs == 0 &&
            pixChk.passCount == tbl.size()) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog limit is twice the summed wait lengths
    initial begin
        @(posedge arstN);
        repeat (2 * waitSum) @(posedge Clock);
        $display("timeout: run did not finish within %0d cycles", 2 * waitSum);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/pixelChecker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tile_settings.svh"

// rebuilds tile frames from the pixel stream and checks them
module pixelChecker (
    input logic             Clock,
    input logic             arstN,
    input drawPkg::xCoord   x,
    input drawPkg::yCoord   y,
    input drawPkg::pixColor color,
    input logic             write
);
    import drawPkg::*;

    localparam int framePix = `TILE_W * `TILE_H;
    localparam int lastRow  = `SCREEN_H - `TILE_H;      // draw here, then wrap
    localparam int white    = (1 << `COLOR_BITS) - 1;

    string testName   = "reset";
    int    passCount  = 0;
    int    failCount  = 0;
    int    testErrs   = 0;
    int    curTile    = 0;         // owner of the open frame
    int    pixIdx     = 0;         // pixels seen in the open frame
    int    frameRow   = 0;
    int    lastColor  = 0;
    bit    frameErase = 1'b0;
    int    eraseOwner = -1;        // tile whose draw frame must come next
    int    drawRow    [`NUM_TILES];
    int    drawColor  [`NUM_TILES];
    int    drawFrames [`NUM_TILES]; // counted per test
    int    wraps      [`NUM_TILES];
    bit    seenFrame  [`NUM_TILES];

    initial begin
        for (int t = 0; t < `NUM_TILES; t++) begin
            drawRow[t]    = 0;      // tile 1 initial draw overlaps tile 0, so it is never forwarded
            drawColor[t]  = -1;     // nothing drawn yet
            drawFrames[t] = 0;
            wraps[t]      = 0;
            seenFrame[t]  = 1'b0;
        end
    end

    task automatic mismatch(input string what, input int expV, input int actV);
        $display("FAIL %s %s: expected %0d actual %0d", testName, what, expV, actV);
        testErrs++;
    endtask

    task automatic problem(input string msg);
        $display("ERROR %s: %s", testName, msg);
        testErrs++;
    endtask

    task automatic closeFrame();
        int expRow;
        if (frameErase) begin
            if (eraseOwner >= 0) problem("erase frame while another redraw was open");
            if (frameRow != drawRow[curTile]) mismatch("erase row", drawRow[curTile], frameRow);
            eraseOwner = curTile;
        end else begin
            if (eraseOwner >= 0) begin
                if (curTile != eraseOwner) problem("another tile drew between erase and draw");
                expRow = (drawRow[curTile] == lastRow) ? 0 : drawRow[curTile] + 1;
                if (expRow == 0) wraps[curTile]++;
            end else begin
                if (seenFrame[curTile]) problem("draw frame without an erase before it");
                expRow = 0;                             // first draw after reset
                if (lastColor != white) mismatch("initial colour", white, lastColor);
            end
            if (frameRow != expRow) mismatch("draw row", expRow, frameRow);
            drawRow[curTile]   = frameRow;
            drawColor[curTile] = lastColor;
            drawFrames[curTile]++;
            eraseOwner = -1;
        end
        seenFrame[curTile] = 1'b1;
    endtask

    task automatic takePixel();
        int xv, yv, cv, tile;
        xv   = int'(x);
        yv   = int'(y);
        cv   = int'(color);
        tile = xv / `LANE_W;                           // lane gives the tile
        if (pixIdx != 0 && tile != curTile) begin
            problem("frame cut short by a write from another tile");
            pixIdx = 0;
        end
        if (pixIdx == 0) begin
            curTile    = tile;
            frameRow   = yv;
            frameErase = (cv == 0);
        end else if ((cv == 0) != frameErase) begin
            problem("erase and draw pixels mixed in one frame");
        end
        // row-major pixel order within the tile
        if (xv != tile * `LANE_W + pixIdx % `TILE_W)
            mismatch("pixel x", tile * `LANE_W + pixIdx % `TILE_W, xv);
        if (yv != frameRow + pixIdx / `TILE_W)
            mismatch("pixel y", frameRow + pixIdx / `TILE_W, yv);
        lastColor = cv;                                 // colour may change mid frame
        pixIdx++;
        if (pixIdx == framePix) begin
            closeFrame();
            pixIdx = 0;
        end
    endtask

    always @(posedge Clock) begin
        if (arstN && write) takePixel();
    end

    task automatic startTest(input string name);
        testName = name;
        for (int t = 0; t < `NUM_TILES; t++) drawFrames[t] = 0;
    endtask

    task automatic endTest(input int exp0, input int exp1, input bit speedChk, input bit wrapChk);
        int expCol [`NUM_TILES];
        expCol[0] = exp0;
        expCol[1] = exp1;
        for (int t = 0; t < `NUM_TILES; t++) begin
            if (drawColor[t] < 0) problem($sformatf("no draw frame seen from tile %0d", t));
            else if (drawColor[t] != expCol[t])
                mismatch($sformatf("tile %0d colour", t), expCol[t], drawColor[t]);
        end
        if (speedChk && drawFrames[0] <= drawFrames[1]) begin
            $display("FAIL %s tile 0 draw frames: expected more than %0d actual %0d",
                     testName, drawFrames[1], drawFrames[0]);
            testErrs++;
        end
        if (wrapChk && wraps[0] == 0) problem("tile 0 never wrapped back to row 0");
        if (testErrs == 0) begin
            passCount++;
            $display("PASS %s", testName);
        end else begin
            failCount++;
            $display("FAIL %s: errors expected 0 actual %0d", testName, testErrs);
        end
        testErrs = 0;                                   // later errors go to the next test
    endtask

    task automatic reportCounts();
        $display("summary: %0d passed, %0d failed", passCount, failCount);
    endtask

endmodule

`default_nettype wire

/* rtl/tileDisplay.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tile_settings.svh"

module tileDisplay (
    input  logic             Clock,
    input  logic             arstN,
    input  logic             keySetColor,   // keys active high, may be held
    input  logic             keyFaster,
    input  logic             keySlower,
    input  drawPkg::tileIdx  selTile,       // tile that gets the key commands
    input  drawPkg::pixColor newColor,
    output drawPkg::xCoord   pixX,          // pixel write stream
    output drawPkg::yCoord   pixY,
    output drawPkg::pixColor pixColor,
    output logic             pixWrite
);

    pixelBus   pixBus [`NUM_TILES] ();      // tile to arbiter
    tileCmdBus cmdBus [`NUM_TILES] ();      // decode to tile

    keyDecode uKeys (
        .Clock       (Clock),
        .arstN       (arstN),
        .keySetColor (keySetColor),
        .keyFaster   (keyFaster),
        .keySlower   (keySlower),
        .selTile     (selTile),
        .newColor    (newColor),
        .cmd         (cmdBus)
    );

    // one animator per lane
    for (genvar i = 0; i < `NUM_TILES; i++) begin : gTile
        tileAnimator #(.laneIdx(i)) uTile (
            .Clock (Clock),
            .arstN (arstN),
            .cmd   (cmdBus[i]),
            .pix   (pixBus[i])
        );
    end

    drawArbiter uArb (
        .Clock    (Clock),
        .arstN    (arstN),
        .pix      (pixBus),
        .pixX     (pixX),
        .pixY     (pixY),
        .pixColor (pixColor),
        .pixWrite (pixWrite)
    );

endmodule

`default_nettype wire

/* rtl/drawArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tile_settings.svh"

module drawArbiter (
    input  logic             Clock,
    input  logic             arstN,
    pixelBus.arbiter         pix [`NUM_TILES],
    output drawPkg::xCoord   pixX,
    output drawPkg::yCoord   pixY,
    output drawPkg::pixColor pixColor,
    output logic             pixWrite
);
    import drawPkg::*;
    import ctrlPkg::*;

    arbState stQ, stD;
    tileIdx  curIdx, srcIdx;                        // granted tile, muxed tile
    logic [`NUM_TILES-1:0] reqVec, wrVec;
    xCoord xVec [`NUM_TILES];
    yCoord yVec [`NUM_TILES];
    logic [`COLOR_BITS-1:0] colVec [`NUM_TILES];

    // flatten the bus array so it can be indexed at run time
    for (genvar i = 0; i < `NUM_TILES; i++) begin : gFlat
        assign reqVec[i] = pix[i].req;
        assign wrVec[i]  = pix[i].write;
        assign xVec[i]   = pix[i].x;
        assign yVec[i]   = pix[i].y;
        assign colVec[i] = pix[i].color;
        assign pix[i].gnt = (stQ == arbState'(i + 1));   // high for the whole grant
    end

    assign curIdx = tileIdx'(stQ - 1'b1);

    always_comb begin
        stD = stQ;
        if (stQ == arbIdle) begin
            for (int i = `NUM_TILES - 1; i >= 0; i--) begin
                if (reqVec[i]) stD = arbState'(i + 1);   // lowest index wins
            end
        end else if (!reqVec[curIdx]) begin
            stD = arbIdle;                          // tile released
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) stQ <= arbIdle;
        else stQ <= stD;
    end

    // idle forwards any writing tile, which covers the initial draws
    always_comb begin
        srcIdx = curIdx;
        if (stQ == arbIdle) begin
            srcIdx = '0;
            for (int i = `NUM_TILES - 1; i >= 0; i--) begin
                if (wrVec[i]) srcIdx = tileIdx'(i);
            end
        end
    end

    assign pixX     = xVec[srcIdx];
    assign pixY     = yVec[srcIdx];
    assign pixColor = colVec[srcIdx];
    assign pixWrite = wrVec[srcIdx];

endmodule

`default_nettype wire

/* rtl/tileAnimator.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tile_settings.svh"

module tileAnimator #(
    parameter int laneIdx = 0                       // picks the lane, fixes x origin
) (
    input  logic     Clock,
    input  logic     arstN,
    tileCmdBus.sink  cmd,
    pixelBus.tile    pix
);
    import drawPkg::*;
    import ctrlPkg::*;

    localparam int    colBits = $clog2(`TILE_W);
    localparam int    rowBits = $clog2(`TILE_H);
    localparam xCoord laneX   = xCoord'(laneIdx * `LANE_W);
    localparam yCoord lastRow = yCoord'(`SCREEN_H - `TILE_H);  // wrap point
    localparam int    padBits = `SPEED_BITS - `MASK_BITS;

    tileState stQ, stD;
    logic [colBits-1:0] colCnt;                     // pixel within a tile row
    logic [rowBits-1:0] rowCnt;                     // row within the tile
    yCoord   rowOrg;                                // tile top row on screen
    logic    atBottom;
    pixColor colorReg, shownColor;
    logic [`SPEED_BITS-1:0] speedCnt;
    logic [`MASK_BITS-1:0]  speedMask;
    logic    strobe, colDone, rowDone, inPixel, inRowStep, erasing;

    assign colDone   = (colCnt == colBits'(`TILE_W - 1));
    assign rowDone   = (rowCnt == rowBits'(`TILE_H - 1));
    assign inPixel   = stQ inside {tsInitDrawPixel, tsErasePixel, tsDrawPixel};
    assign inRowStep = stQ inside {tsInitDrawRow, tsEraseRow, tsDrawRow};
    assign erasing   = stQ inside {tsErasePixel, tsEraseRow};

    // masked top bits count as ones, so more mask ones means a shorter wait
    assign strobe = ((speedCnt | {speedMask, {padBits{1'b0}}}) == '1);

    always_comb begin
        stD = stQ;
        case (stQ)
            tsInit:          stD = tsInitDrawPixel;
            tsInitDrawPixel: if (colDone) stD = tsInitDrawRow;
            tsInitDrawRow:   stD = rowDone ? tsWaitDelay : tsInitDrawPixel;
            tsWaitDelay:     if (strobe) stD = tsWaitGrant;   // req rises next
            tsWaitGrant:     if (pix.gnt) stD = tsErasePixel;
            tsErasePixel:    if (colDone) stD = tsEraseRow;
            tsEraseRow:      stD = rowDone ? tsMoveCheck : tsErasePixel;
            tsMoveCheck:     stD = tsMoveStep;
            tsMoveStep:      stD = tsDrawPixel;
            tsDrawPixel:     if (colDone) stD = tsDrawRow;
            tsDrawRow:       stD = rowDone ? tsRelease : tsDrawPixel;
            tsRelease:       stD = tsWaitDelay;
            default:         stD = tsInit;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            stQ    <= tsInit;
            colCnt <= '0;
            rowCnt <= '0;
            rowOrg <= '0;
        end else begin
            stQ <= stD;
            if (stQ == tsInit) begin
                colCnt <= '0;
                rowCnt <= '0;
                rowOrg <= '0;
            end
            if (inPixel) colCnt <= colDone ? '0 : colCnt + 1'b1;
            if (inRowStep) rowCnt <= rowDone ? '0 : rowCnt + 1'b1;
            if (stQ == tsMoveStep) rowOrg <= atBottom ? '0 : rowOrg + 1'b1;
        end
    end

    // bottom check captured ahead of the move
    always_ff @(posedge Clock) begin
        if (stQ == tsMoveCheck) atBottom <= (rowOrg == lastRow);
    end

    // colour register, zero reads as white
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) colorReg <= '0;
        else if (cmd.setColor) colorReg <= cmd.newColor;
        else if (colorReg == '0) colorReg <= '1;
    end
    assign shownColor = (colorReg == '0) ? '1 : colorReg;

    // speed counter runs freely, mask shifts on commands
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            speedCnt  <= '0;
            speedMask <= '0;
        end else begin
            speedCnt <= speedCnt + 1'b1;
            if (cmd.faster) speedMask <= {1'b1, speedMask[`MASK_BITS-1:1]};     // 1 in at top
            else if (cmd.slower) speedMask <= {speedMask[`MASK_BITS-2:0], 1'b0}; // 0 in at bottom
        end
    end

    assign pix.req   = stQ inside {tsWaitGrant, tsErasePixel, tsEraseRow, tsMoveCheck,
                                   tsMoveStep, tsDrawPixel, tsDrawRow};
    assign pix.write = inPixel;
    assign pix.x     = laneX + xCoord'(colCnt);
    assign pix.y     = rowOrg + yCoord'(rowCnt);
    assign pix.color = erasing ? '0 : shownColor;  // erase in black

endmodule

`default_nettype wire

/* rtl/keyDecode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tile_settings.svh"

module keyDecode (
    input  logic            Clock,
    input  logic            arstN,
    input  logic            keySetColor,
    input  logic            keyFaster,
    input  logic            keySlower,
    input  drawPkg::tileIdx selTile,
    input  drawPkg::pixColor newColor,
    tileCmdBus.source       cmd [`NUM_TILES]
);
    import drawPkg::*;
    import ctrlPkg::*;

    localparam int numKeys = 3;

    logic [numKeys-1:0] keyRaw, syncA, syncB;
    logic [numKeys-1:0] pulse;                      // one cycle per press
    keyState            keyQ [numKeys];

    assign keyRaw = {keySlower, keyFaster, keySetColor};

    // two-flop synchroniser per key
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            syncA <= '0;
            syncB <= '0;
        end else begin
            syncA <= keyRaw;
            syncB <= syncA;
        end
    end

    // press detector, steps once and then waits for release
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < numKeys; k++) keyQ[k] <= ksIdle;
        end else begin
            for (int k = 0; k < numKeys; k++) begin
                case (keyQ[k])
                    ksIdle:  if (syncB[k]) keyQ[k] <= ksStep;
                    ksStep:  keyQ[k] <= syncB[k] ? ksHeld : ksIdle;
                    ksHeld:  if (!syncB[k]) keyQ[k] <= ksIdle;  // released
                    default: keyQ[k] <= ksIdle;
                endcase
            end
        end
    end

    always_comb begin
        for (int k = 0; k < numKeys; k++) pulse[k] = (keyQ[k] == ksStep);
    end

    // only the selected tile sees the pulses
    for (genvar i = 0; i < `NUM_TILES; i++) begin : gRoute
        logic hit;
        assign hit                = (selTile == tileIdx'(i));
        assign cmd[i].setColor    = pulse[0] & hit;
        assign cmd[i].faster      = pulse[1] & hit;
        assign cmd[i].slower      = pulse[2] & hit;
        assign cmd[i].newColor    = newColor;       // passed through as is
    end

endmodule

`default_nettype wire

/* rtl/tileCmdBus.sv */
`timescale 1ns/10ps
`default_nettype none

// commands from key decode to one tile
interface tileCmdBus;
    import drawPkg::*;

    logic    setColor;   // single-cycle pulses
    logic    faster;
    logic    slower;
    pixColor newColor;   // level, sampled on setColor

    modport source (output setColor, faster, slower, newColor);

    modport sink (input setColor, faster, slower, newColor);

endinterface

`default_nettype wire

/* rtl/pixelBus.sv */
`timescale 1ns/10ps
`default_nettype none

// one tile's link to the draw arbiter
interface pixelBus;
    import drawPkg::*;

    logic    req;      // tile wants a redraw cycle
    logic    gnt;      // arbiter has picked this tile
    xCoord   x;
    yCoord   y;
    pixColor color;
    logic    write;    // pixel write strobe

    modport tile (output req, x, y, color, write, input gnt);

    modport arbiter (input req, x, y, color, write, output gnt);

endinterface

`default_nettype wire

/* rtl/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    // one pulse per press, then hold until release
    typedef enum logic [1:0] {ksIdle, ksStep, ksHeld} keyState;

    typedef enum logic [3:0] {
        tsInit, tsInitDrawPixel, tsInitDrawRow,  // first draw, no grant needed
        tsWaitDelay, tsWaitGrant,
        tsErasePixel, tsEraseRow,
        tsMoveCheck, tsMoveStep,
        tsDrawPixel, tsDrawRow,
        tsRelease                                // req drops here
    } tileState;

    // idle plus one grant state per tile
    typedef enum logic [1:0] {arbIdle, arbGrant0, arbGrant1} arbState;

endpackage

`default_nettype wire

/* rtl/drawPkg.sv */
`default_nettype none

`include "tile_settings.svh"

package drawPkg;

    // widths derived from the frame and tile count
    localparam int xBits   = $clog2(`SCREEN_W);
    localparam int yBits   = $clog2(`SCREEN_H);
    localparam int idxBits = (`NUM_TILES > 1) ? $clog2(`NUM_TILES) : 1;

    typedef logic [xBits-1:0] xCoord;            // pixel column
    typedef logic [yBits-1:0] yCoord;            // pixel row

    // 3-bit colour, all ones is white and zero is the erase colour
    typedef logic [`COLOR_BITS-1:0] pixColor;

    typedef logic [idxBits-1:0] tileIdx;         // tile number

endpackage

`default_nettype wire

/* rtl/tile_settings.svh */
`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

`define SCREEN_W   64      // frame width in pixels
`define SCREEN_H   32      // frame height in pixels

`define NUM_TILES  2       // one tile per lane
`define LANE_W     32      // lane width, tile x origin is index times this

`define TILE_W     8
`define TILE_H     4

`define COLOR_BITS 3
`define SPEED_BITS 8       // free-running speed counter
`define MASK_BITS  4       // speed mask covers the top bits of the counter

`endif
